//--- src/cache_pkg.sv
package cache_pkg;

  // Address geometry, laid out as [ tag | index | word | byte ]
  localparam int addr_w         = 32;
  localparam int data_w         = 32;
  localparam int strb_w         = data_w / 8;
  localparam int offset_bits    = 4;
  localparam int word_sel_bits  = 2;
  localparam int words_per_line = 1 << word_sel_bits;
  localparam int index_bits     = 4;
  localparam int num_lines      = 1 << index_bits;
  localparam int tag_bits       = addr_w - index_bits - offset_bits;

  typedef logic [addr_w-1:0]        addr_t;
  typedef logic [data_w-1:0]        data_t;
  typedef logic [strb_w-1:0]        strb_t;
  typedef logic [tag_bits-1:0]      tag_t;
  typedef logic [index_bits-1:0]    index_t;
  typedef logic [word_sel_bits-1:0] word_sel_t;

  typedef logic [words_per_line-1:0][data_w-1:0] line_t;

  typedef struct packed {
    logic valid;
    logic dirty;
  } line_meta_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,
    ST_REFILL_REQ,
    ST_REFILL_WAIT,
    ST_RELOOKUP
  } ctrl_state_t;

  function automatic tag_t get_tag(input addr_t a);
    return a[addr_w-1 -: tag_bits];
  endfunction

  function automatic index_t get_index(input addr_t a);
    return a[offset_bits +: index_bits];
  endfunction

  function automatic word_sel_t get_word_sel(input addr_t a);
    return a[offset_bits-1 -: word_sel_bits];
  endfunction

endpackage

//--- src/cache_req_if.sv
// One accepted request, held from acceptance until the response completes
interface cache_req_if;

  logic              valid;
  cache_pkg::addr_t  addr;
  logic              is_write;
  cache_pkg::data_t  wdata;
  cache_pkg::strb_t  wstrb;

  modport src (
    output valid,
    output addr,
    output is_write,
    output wdata,
    output wstrb
  );

  modport dst (
    input valid,
    input addr,
    input is_write,
    input wdata,
    input wstrb
  );

endinterface

//--- src/cache_accept.sv
module cache_accept (
  input  logic                clk,
  input  logic                rst,
  input  cache_pkg::addr_t    araddr,
  input  logic                arvalid,
  output logic                arready,
  input  cache_pkg::addr_t    awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  cache_pkg::data_t    wdata,
  input  cache_pkg::strb_t    wstrb,
  input  logic                wvalid,
  output logic                wready,
  input  logic                done,
  output cache_pkg::index_t   rd_index,
  cache_req_if.src            req
);

  logic             running;
  logic             free;
  logic             wr_offered;
  logic             take_wr;
  logic             take_rd;
  logic             accept;
  cache_pkg::addr_t acc_addr;

  // Free when nothing is held, or the held request finishes this cycle
  assign free       = running && (!req.valid || done);
  assign wr_offered = awvalid && wvalid;

  // Address and data of a write move together, and a write beats a read
  assign awready = free && wr_offered;
  assign wready  = awready;
  assign arready = free && !wr_offered;

  assign take_wr  = awready;
  assign take_rd  = arready && arvalid;
  assign accept   = take_wr || take_rd;
  assign acc_addr = take_wr ? awaddr : araddr;

  // The RAMs start their read on the accepting edge
  assign rd_index = accept ? cache_pkg::get_index(acc_addr) : cache_pkg::get_index(req.addr);

  always_ff @(posedge clk) begin
    if (rst) begin
      running   <= 1'b0;
      req.valid <= 1'b0;
    end else begin
      running <= 1'b1;
      if (accept) begin
        req.valid <= 1'b1;
      end else if (done) begin
        req.valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req.addr     <= acc_addr;
      req.is_write <= take_wr;
      req.wdata    <= wdata;
      req.wstrb    <= wstrb;
    end
  end

  a_wr_ready_pair : assert property (@(posedge clk) awready == wready);

endmodule

//--- src/cache_lookup.sv
module cache_lookup (
  input  logic                  clk,
  input  logic                  rst,
  input  cache_pkg::index_t     rd_index,
  input  logic                  tag_we,
  input  logic                  meta_we,
  input  cache_pkg::line_meta_t meta_wr,
  output logic                  hit,
  output cache_pkg::tag_t       victim_tag,
  output cache_pkg::line_meta_t victim_meta,
  cache_req_if.dst              req
);

  // Tags live in block RAM, valid/dirty in flops so reset can clear them
  cache_pkg::tag_t       tag_ram  [cache_pkg::num_lines];
  cache_pkg::line_meta_t meta_arr [cache_pkg::num_lines];

  cache_pkg::tag_t       tag_q;
  cache_pkg::line_meta_t meta_q;
  cache_pkg::index_t     wr_index;
  cache_pkg::tag_t       req_tag;

  assign wr_index = cache_pkg::get_index(req.addr);
  assign req_tag  = cache_pkg::get_tag(req.addr);

  // Tags change only during a refill, while no new request can be accepted
  always_ff @(posedge clk) begin
    if (tag_we) begin
      tag_ram[wr_index] <= req_tag;
    end
    tag_q <= tag_ram[rd_index];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      meta_arr <= '{default: '0};
      meta_q   <= '0;
    end else begin
      if (meta_we) begin
        meta_arr[wr_index] <= meta_wr;
      end
      // A write hit can mark a line dirty on the edge that accepts the next request
      if (meta_we && (wr_index == rd_index)) begin
        meta_q <= meta_wr;
      end else begin
        meta_q <= meta_arr[rd_index];
      end
    end
  end

  assign hit         = meta_q.valid && (tag_q == req_tag);
  assign victim_tag  = tag_q;
  assign victim_meta = meta_q;

  // Meta only changes on behalf of a held request
  a_meta_we_valid : assert property (@(posedge clk) disable iff (rst)
    meta_we |-> req.valid);

  // A new tag always comes with a clean valid line
  a_tag_with_meta : assert property (@(posedge clk) disable iff (rst)
    tag_we |-> meta_we && meta_wr.valid && !meta_wr.dirty);

endmodule

//--- src/cache_line_store.sv
module cache_line_store (
  input  logic                                 clk,
  input  cache_pkg::index_t                    rd_index,
  input  logic [cache_pkg::words_per_line-1:0] word_we,
  input  cache_pkg::line_t                     wr_line,
  output cache_pkg::line_t                     rd_line,
  cache_req_if.dst                             req
);

  cache_pkg::index_t wr_index;

  assign wr_index = cache_pkg::get_index(req.addr);

  // One RAM per word so a write hit touches a single word
  for (genvar w = 0; w < cache_pkg::words_per_line; w++) begin : g_word
    cache_pkg::data_t mem [cache_pkg::num_lines];
    cache_pkg::data_t rd_word;

    always_ff @(posedge clk) begin
      if (word_we[w]) begin
        mem[wr_index] <= wr_line[w];
      end
      // Write-first, so a request accepted on the edge of a write hit sees the new word
      if (word_we[w] && (wr_index == rd_index)) begin
        rd_word <= wr_line[w];
      end else begin
        rd_word <= mem[rd_index];
      end
    end

    assign rd_line[w] = rd_word;
  end

endmodule

//--- src/cache_miss_ctrl.sv
module cache_miss_ctrl (
  input  logic                                 clk,
  input  logic                                 rst,
  output cache_pkg::data_t                     rdata,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic                                 bvalid,
  input  logic                                 bready,
  output logic                                 done,
  output logic                                 mem_req_valid,
  input  logic                                 mem_req_ready,
  output cache_pkg::addr_t                     mem_req_addr,
  output logic                                 mem_req_write,
  output cache_pkg::line_t                     mem_req_wdata,
  input  logic                                 mem_resp_valid,
  input  cache_pkg::line_t                     mem_resp_rdata,
  input  logic                                 hit,
  input  cache_pkg::tag_t                      victim_tag,
  input  cache_pkg::line_meta_t                victim_meta,
  output logic                                 tag_we,
  output logic                                 meta_we,
  output cache_pkg::line_meta_t                meta_wr,
  output logic [cache_pkg::words_per_line-1:0] word_we,
  output cache_pkg::line_t                     wr_line,
  input  cache_pkg::line_t                     rd_line,
  cache_req_if.dst                             req
);

  cache_pkg::ctrl_state_t state;
  cache_pkg::ctrl_state_t state_next;
  cache_pkg::word_sel_t   word_sel;
  cache_pkg::index_t      index;
  cache_pkg::data_t       cur_word;
  cache_pkg::data_t       merged_word;
  cache_pkg::addr_t       line_base;
  cache_pkg::addr_t       victim_base;

  assign word_sel    = cache_pkg::get_word_sel(req.addr);
  assign index       = cache_pkg::get_index(req.addr);
  assign cur_word    = rd_line[word_sel];
  assign line_base   = {cache_pkg::get_tag(req.addr), index, {cache_pkg::offset_bits{1'b0}}};
  assign victim_base = {victim_tag, index, {cache_pkg::offset_bits{1'b0}}};

  // rd_line holds still while a response waits, so rdata does too
  assign rdata         = cur_word;
  assign mem_req_wdata = rd_line;

  always_comb begin
    for (int b = 0; b < cache_pkg::strb_w; b++) begin
      merged_word[b*8 +: 8] = req.wstrb[b] ? req.wdata[b*8 +: 8] : cur_word[b*8 +: 8];
    end
  end

  always_comb begin
    state_next    = state;
    rvalid        = 1'b0;
    bvalid        = 1'b0;
    done          = 1'b0;
    mem_req_valid = 1'b0;
    mem_req_addr  = line_base;
    mem_req_write = 1'b0;
    tag_we        = 1'b0;
    meta_we       = 1'b0;
    meta_wr       = '0;
    word_we       = '0;
    wr_line       = {cache_pkg::words_per_line{merged_word}};

    case (state)
      // A fresh request is looked up straight from idle
      cache_pkg::ST_IDLE, cache_pkg::ST_LOOKUP: begin
        if (!req.valid) begin
          state_next = cache_pkg::ST_IDLE;
        end else if (hit && req.is_write) begin
          bvalid            = 1'b1;
          word_we[word_sel] = 1'b1;
          meta_we           = 1'b1;
          meta_wr           = '{valid: 1'b1, dirty: 1'b1};
          done              = bready;
          state_next        = bready ? cache_pkg::ST_IDLE : cache_pkg::ST_LOOKUP;
        end else if (hit) begin
          rvalid     = 1'b1;
          done       = rready;
          state_next = rready ? cache_pkg::ST_IDLE : cache_pkg::ST_LOOKUP;
        end else if (victim_meta.valid && victim_meta.dirty) begin
          state_next = cache_pkg::ST_WRITEBACK;
        end else begin
          state_next = cache_pkg::ST_REFILL_REQ;
        end
      end

      // Victim goes out first, read straight from the line RAM
      cache_pkg::ST_WRITEBACK: begin
        mem_req_valid = 1'b1;
        mem_req_write = 1'b1;
        mem_req_addr  = victim_base;
        if (mem_req_ready) begin
          state_next = cache_pkg::ST_REFILL_REQ;
        end
      end

      cache_pkg::ST_REFILL_REQ: begin
        mem_req_valid = 1'b1;
        if (mem_req_ready) begin
          state_next = cache_pkg::ST_REFILL_WAIT;
        end
      end

      cache_pkg::ST_REFILL_WAIT: begin
        if (mem_resp_valid) begin
          word_we    = '1;
          wr_line    = mem_resp_rdata;
          tag_we     = 1'b1;
          meta_we    = 1'b1;
          meta_wr    = '{valid: 1'b1, dirty: 1'b0};
          state_next = cache_pkg::ST_RELOOKUP;
        end
      end

      // Burn one cycle so tag, meta and data are read back together
      cache_pkg::ST_RELOOKUP: begin
        state_next = cache_pkg::ST_LOOKUP;
      end

      default: begin
        state_next = cache_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cache_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  a_one_response : assert property (@(posedge clk) disable iff (rst)
    !(rvalid && bvalid));

  // Memory request and its fields hold until taken
  a_mem_req_hold : assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && !mem_req_ready |=>
      mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_write));

endmodule

//--- src/cache_top.sv
module cache_top (
  input  logic             clk,
  input  logic             rst,
  // Read channel
  input  cache_pkg::addr_t araddr,
  input  logic             arvalid,
  output logic             arready,
  output cache_pkg::data_t rdata,
  output logic             rvalid,
  input  logic             rready,
  // Write channel
  input  cache_pkg::addr_t awaddr,
  input  cache_pkg::data_t wdata,
  input  cache_pkg::strb_t wstrb,
  input  logic             awvalid,
  input  logic             wvalid,
  output logic             awready,
  output logic             wready,
  output logic             bvalid,
  input  logic             bready,
  // Line-wide memory channel
  output logic             mem_req_valid,
  input  logic             mem_req_ready,
  output cache_pkg::addr_t mem_req_addr,
  output logic             mem_req_write,
  output cache_pkg::line_t mem_req_wdata,
  input  logic             mem_resp_valid,
  input  cache_pkg::line_t mem_resp_rdata
);

  logic                                 done;
  cache_pkg::index_t                    rd_index;
  logic                                 hit;
  cache_pkg::tag_t                      victim_tag;
  cache_pkg::line_meta_t                victim_meta;
  logic                                 tag_we;
  logic                                 meta_we;
  cache_pkg::line_meta_t                meta_wr;
  logic [cache_pkg::words_per_line-1:0] word_we;
  cache_pkg::line_t                     wr_line;
  cache_pkg::line_t                     rd_line;

  cache_req_if req ();

  cache_accept i_accept (
    .clk, .rst,
    .araddr, .arvalid, .arready,
    .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .done, .rd_index,
    .req (req.src)
  );

  cache_lookup i_lookup (
    .clk, .rst, .rd_index,
    .tag_we, .meta_we, .meta_wr,
    .hit, .victim_tag, .victim_meta,
    .req (req.dst)
  );

  cache_line_store i_line_store (
    .clk, .rd_index, .word_we, .wr_line, .rd_line,
    .req (req.dst)
  );

  cache_miss_ctrl i_miss_ctrl (
    .clk, .rst,
    .rdata, .rvalid, .rready, .bvalid, .bready, .done,
    .mem_req_valid, .mem_req_ready, .mem_req_addr, .mem_req_write, .mem_req_wdata,
    .mem_resp_valid, .mem_resp_rdata,
    .hit, .victim_tag, .victim_meta,
    .tag_we, .meta_we, .meta_wr, .word_we, .wr_line, .rd_line,
    .req (req.dst)
  );

endmodule

//--- verif/cache_checker.sv
module cache_checker (
  input  logic             clk,
  input  logic             rst,
  input  cache_pkg::addr_t araddr,
  input  logic             arvalid,
  input  logic             arready,
  input  cache_pkg::data_t rdata,
  input  logic             rvalid,
  input  logic             rready,
  input  cache_pkg::addr_t awaddr,
  input  cache_pkg::data_t wdata,
  input  cache_pkg::strb_t wstrb,
  input  logic             awvalid,
  input  logic             awready,
  input  logic             wready,
  input  logic             bvalid,
  input  logic             bready,
  input  logic             mem_req_valid,
  input  logic             mem_req_ready,
  input  cache_pkg::addr_t mem_req_addr,
  input  logic             mem_req_write,
  input  cache_pkg::line_t mem_req_wdata,
  output int               errors,
  output int               checks
);
  timeunit 1ns;
  timeprecision 1ps;

  // Bytes written so far; untouched bytes follow the memory fill rule
  logic [7:0]       shadow [cache_pkg::addr_t];
  cache_pkg::addr_t rd_addr;
  cache_pkg::data_t held_rdata;
  logic             held;

  function automatic cache_pkg::data_t ref_word(input cache_pkg::addr_t a);
    cache_pkg::addr_t base;
    cache_pkg::data_t word;
    base = {a[cache_pkg::addr_w-1:2], 2'b00};
    word = ~base;
    for (int b = 0; b < cache_pkg::strb_w; b++) begin
      if (shadow.exists(base + b)) begin
        word[b*8 +: 8] = shadow[base + b];
      end
    end
    return word;
  endfunction

  task automatic flag_mismatch(input string name, input cache_pkg::data_t got,
                               input cache_pkg::data_t exp, input cache_pkg::addr_t a);
    errors++;
    $display("error: %s = 0x%08h, expected 0x%08h at address 0x%08h", name, got, exp, a);
  endtask

  task automatic flag_protocol(input string what);
    errors++;
    $display("at %0t ns: %s", $time, what);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    held   = 1'b0;
  end

  always @(posedge clk) begin
    if (!rst) begin
      // A stalled response must hold its word
      if (held && !rvalid) begin
        flag_protocol("rvalid dropped before rready was seen");
      end else if (held && rdata !== held_rdata) begin
        flag_mismatch("rdata", rdata, held_rdata, rd_addr);
      end
      if (rvalid && rready) begin
        checks++;
        if (rdata !== ref_word(rd_addr)) begin
          flag_mismatch("rdata", rdata, ref_word(rd_addr), rd_addr);
        end
      end
      if (arready && rvalid && !rready) begin
        flag_protocol("arready raised while a read response was stalled");
      end
      if ((arready || awready) && bvalid && !bready) begin
        flag_protocol("ready raised while a write response was stalled");
      end
      if (wready !== awready) begin
        errors++;
        $display("error: wready = 0x%0h, expected 0x%0h", wready, awready);
      end
      // Write-back data must match the architectural line
      if (mem_req_valid && mem_req_ready && mem_req_write) begin
        for (int w = 0; w < cache_pkg::words_per_line; w++) begin
          checks++;
          if (mem_req_wdata[w] !== ref_word(mem_req_addr + 4 * w)) begin
            flag_mismatch("mem_req_wdata", mem_req_wdata[w],
                          ref_word(mem_req_addr + 4 * w), mem_req_addr + 4 * w);
          end
        end
      end
      // New requests are recorded after the responses of this edge
      if (arvalid && arready) begin
        rd_addr = araddr;
      end
      if (awvalid && awready) begin
        for (int b = 0; b < cache_pkg::strb_w; b++) begin
          if (wstrb[b]) begin
            shadow[{awaddr[cache_pkg::addr_w-1:2], 2'b00} + b] = wdata[b*8 +: 8];
          end
        end
      end
      held       = rvalid && !rready;
      held_rdata = rdata;
    end
  end

endmodule

//--- verif/cache_tb.sv
module cache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int resp_timeout = 200;

  logic             clk;
  logic             rst;
  cache_pkg::addr_t araddr;
  logic             arvalid;
  logic             arready;
  cache_pkg::data_t rdata;
  logic             rvalid;
  logic             rready;
  cache_pkg::addr_t awaddr;
  cache_pkg::data_t wdata;
  cache_pkg::strb_t wstrb;
  logic             awvalid;
  logic             wvalid;
  logic             awready;
  logic             wready;
  logic             bvalid;
  logic             bready;
  logic             mem_req_valid;
  logic             mem_req_ready;
  cache_pkg::addr_t mem_req_addr;
  logic             mem_req_write;
  cache_pkg::line_t mem_req_wdata;
  logic             mem_resp_valid;
  cache_pkg::line_t mem_resp_rdata;
  int               errors;
  int               checks;
  int               seq_errors;
  int               err_mark;
  logic             timed_out;
  int               wb_count;
  cache_pkg::addr_t last_wb_addr;
  cache_pkg::addr_t resp_addr;

  // Words never written back read as the inverse of their byte address
  cache_pkg::data_t mem_words [cache_pkg::addr_t];

  cache_top i_cache_top (.*);

  cache_checker i_checker (.*);

  always #20 clk = ~clk;

  function automatic cache_pkg::data_t mem_word(input cache_pkg::addr_t a);
    return mem_words.exists(a) ? mem_words[a] : ~a;
  endfunction

  always @(negedge clk) begin
    mem_req_ready = ($urandom % 3) != 0;
  end

  // Line memory: write-backs land at once, refills answer after 1 to 6 cycles
  always begin
    @(posedge clk);
    if (!rst && mem_req_valid && mem_req_ready) begin
      if (mem_req_write) begin
        for (int w = 0; w < cache_pkg::words_per_line; w++) begin
          mem_words[mem_req_addr + 4 * w] = mem_req_wdata[w];
        end
        wb_count++;
        last_wb_addr = mem_req_addr;
      end else begin
        resp_addr = mem_req_addr;
        repeat (1 + $urandom % 6) @(negedge clk);
        for (int w = 0; w < cache_pkg::words_per_line; w++) begin
          mem_resp_rdata[w] = mem_word(resp_addr + 4 * w);
        end
        mem_resp_valid = 1'b1;
        @(negedge clk);
        mem_resp_valid = 1'b0;
      end
    end
  end

  task automatic finish_run();
    $display("%0d checks, %0d errors%s", checks, errors + seq_errors,
             timed_out ? ", run timed out" : "");
    if (errors + seq_errors == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    timed_out = 1'b1;
    finish_run();
  endtask

  task automatic wait_accept(input bit is_write);
    int n;
    n = 0;
    @(posedge clk);
    while (!(is_write ? awready : arready)) begin
      n++;
      if (n > resp_timeout) begin
        report_timeout(is_write ? "awready" : "arready");
      end
      @(posedge clk);
    end
  endtask

  task automatic wait_response(input bit is_write, input int stall_pct);
    int   n;
    logic ready;
    n = 0;
    do begin
      if (n == resp_timeout) begin
        report_timeout(is_write ? "bvalid" : "rvalid");
      end
      n++;
      @(negedge clk);
      arvalid = 1'b0;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      ready   = ($urandom % 100) >= stall_pct;
      rready  = !is_write && ready;
      bready  = is_write && ready;
      @(posedge clk);
    end while (!(is_write ? (bvalid && bready) : (rvalid && rready)));
  endtask

  task automatic read_word(input cache_pkg::addr_t addr, input int stall_pct);
    @(negedge clk);
    rready  = 1'b0;
    bready  = 1'b0;
    araddr  = addr;
    arvalid = 1'b1;
    wait_accept(1'b0);
    wait_response(1'b0, stall_pct);
  endtask

  task automatic write_word(input cache_pkg::addr_t addr, input cache_pkg::data_t data,
                            input cache_pkg::strb_t strb, input int stall_pct);
    @(negedge clk);
    rready  = 1'b0;
    bready  = 1'b0;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_accept(1'b1);
    wait_response(1'b1, stall_pct);
  endtask

  task automatic end_test(input string name);
    int n;
    // Let the checker finish the last edge first
    @(negedge clk);
    n        = errors + seq_errors - err_mark;
    err_mark = errors + seq_errors;
    $display("test %s: %0d errors", name, n);
  endtask

  initial begin
    cache_pkg::addr_t a;
    int               wb_before;
    void'($urandom(84152));
    clk            = 1'b0;
    rst            = 1'b1;
    araddr         = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    awaddr         = '0;
    wdata          = '0;
    wstrb          = '0;
    awvalid        = 1'b0;
    wvalid         = 1'b0;
    bready         = 1'b0;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_rdata = '0;
    wb_count       = 0;
    seq_errors     = 0;
    err_mark       = 0;
    timed_out      = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    read_word(32'h0000_1000, 0);
    read_word(32'h0000_1000, 0);
    read_word(32'h0000_100c, 0);
    end_test("read miss then hit");

    write_word(32'h0000_1004, 32'ha5a5_a5a5, 4'b0101, 0);
    read_word(32'h0000_1004, 0);
    write_word(32'h0000_1008, 32'h1234_5678, 4'b1000, 0);
    read_word(32'h0000_1008, 0);
    // Write miss allocates the line before merging
    write_word(32'h0000_2024, 32'hdead_beef, 4'b0011, 0);
    read_word(32'h0000_2024, 0);
    end_test("strobed write merge");

    // Same index, other tag, so the dirty line goes out first
    write_word(32'h0000_3010, 32'h0bad_f00d, 4'b1111, 0);
    wb_before = wb_count;
    read_word(32'h0000_3110, 0);
    if (wb_count != wb_before + 1) begin
      seq_errors++;
      $display("expected one write-back for the evicted line, saw %0d", wb_count - wb_before);
    end else if (last_wb_addr !== 32'h0000_3010) begin
      seq_errors++;
      $display("error: mem_req_addr = 0x%08h, expected 0x%08h", last_wb_addr, 32'h0000_3010);
    end
    read_word(32'h0000_3010, 0);
    end_test("eviction write-back");

    for (int k = 0; k < 12; k++) begin
      read_word(32'h0000_1000 + (($urandom % 64) << 2), 70);
    end
    end_test("back-pressure");

    // 64 lines of addresses over 16 cache lines
    for (int k = 0; k < 300; k++) begin
      a = 32'h0000_4000 + (($urandom % 256) << 2);
      if ($urandom % 2) begin
        write_word(a, $urandom, cache_pkg::strb_t'($urandom), 30);
      end else begin
        read_word(a, 30);
      end
    end
    end_test("random traffic");

    finish_run();
  end

endmodule

//--- project.f
src/cache_pkg.sv
src/cache_req_if.sv
src/cache_accept.sv
src/cache_lookup.sv
src/cache_line_store.sv
src/cache_miss_ctrl.sv
src/cache_top.sv
verif/cache_checker.sv
verif/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  - src/cache_pkg.sv
  - src/cache_req_if.sv
  - src/cache_accept.sv
  - src/cache_lookup.sv
  - src/cache_line_store.sv
  - src/cache_miss_ctrl.sv
  - src/cache_top.sv
  - target: test
    files:
      - verif/cache_checker.sv
      - verif/cache_tb.sv
